// ==== rtc_set_pkg.sv ====
package rtc_set_pkg;

  localparam int RTC_W = 8; // clock data and address width

  typedef enum logic [3:0] {
    ST_INIT   = 4'h0,
    ST_FORMAT = 4'h1, // 12/24 hour select
    ST_SEC    = 4'h2,
    ST_MIN    = 4'h3,
    ST_HOUR   = 4'h4,
    ST_DATE   = 4'h5,
    ST_MONTH  = 4'h6,
    ST_YEAR   = 4'h7,
    ST_WDAY   = 4'h8,
    ST_WEEK   = 4'h9
  } rtc_field_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_HALT,
    CMD_RUN,
    CMD_FORMAT,
    CMD_CLEAR,
    CMD_INC,
    CMD_DEC
  } wr_cmd_t;

  localparam logic [RTC_W-1:0] ADDR_CTRL   = 8'h02;
  localparam logic [RTC_W-1:0] ADDR_FORMAT = 8'h00;
  localparam logic [RTC_W-1:0] ADDR_SEC    = 8'h21;
  localparam logic [RTC_W-1:0] ADDR_MIN    = 8'h22;
  localparam logic [RTC_W-1:0] ADDR_HOUR   = 8'h23;
  localparam logic [RTC_W-1:0] ADDR_DATE   = 8'h24;
  localparam logic [RTC_W-1:0] ADDR_MONTH  = 8'h25;
  localparam logic [RTC_W-1:0] ADDR_YEAR   = 8'h26;
  localparam logic [RTC_W-1:0] ADDR_WDAY   = 8'h27;
  localparam logic [RTC_W-1:0] ADDR_WEEK   = 8'h28;

  localparam logic [RTC_W-1:0] DATA_HALT   = 8'h10; // stop bit in ctrl
  localparam logic [RTC_W-1:0] DATA_RUN    = 8'h00;
  localparam logic [RTC_W-1:0] DATA_FORMAT = 8'h10;
  localparam logic [RTC_W-1:0] DATA_CLEAR  = 8'h00;

endpackage

// ==== key_pulse.sv ====
module key_pulse
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic key_i,
  output logic level_o,
  output logic press_o
);

  logic [1:0] sync_q;
  logic       lvl_q;
  logic       press_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync_q  <= 2'b00;
      lvl_q   <= 1'b0;
      press_q <= 1'b0;
    end
    else
    begin
      sync_q  <= {sync_q[0], key_i}; // two flop synchronizer
      lvl_q   <= sync_q[1];          // previous synced level
      press_q <= sync_q[1] & ~lvl_q; // rise only
    end
  end

  assign level_o = sync_q[1];
  assign press_o = press_q;

  // a held key must give a single pulse per press
  a_press_one_shot: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    press_o |=> !press_o
  );

endmodule

// ==== hold_timer.sv ====
module hold_timer
#(
  parameter int LIMIT = 768,
  parameter int CNT_W = 12
)
(
  input  logic clk,
  input  logic rst_n_i,
  input  logic run_i,
  output logic done_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             done_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end
    else if (!run_i)
    begin
      cnt_q  <= '0; // restart on every release
      done_q <= 1'b0;
    end
    else
    begin
      if (cnt_q != CNT_W'(LIMIT))
      begin
        cnt_q <= cnt_q + 1'b1; // saturates at LIMIT
      end
      done_q <= (cnt_q == CNT_W'(LIMIT));
    end
  end

  assign done_o = done_q;

endmodule

// ==== rtc_set_fsm.sv ====
module rtc_set_fsm
  import rtc_set_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       edit_en_i,
  input  logic       init_lvl_i,
  input  logic       init_press_i,
  input  logic       reset_press_i,
  input  logic       up_i,
  input  logic       down_i,
  input  logic       left_i,
  input  logic       right_i,
  input  logic       init_done_i,
  input  logic       hold_done_i,
  output rtc_field_t field_o,
  output wr_cmd_t    cmd_o,
  output logic       busy_o
);

  rtc_field_t field_q;
  rtc_field_t field_d;
  rtc_field_t field_next;
  rtc_field_t field_prev;
  wr_cmd_t    cmd_q;
  wr_cmd_t    cmd_d;
  logic       busy_q;
  logic       busy_d;
  logic       init_done_q;
  logic       hold_done_q;
  logic       init_rise;
  logic       hold_rise;

  assign init_rise = init_done_i & ~init_done_q;
  assign hold_rise = hold_done_i & ~hold_done_q;

  // fields form a ring, format only enters it
  assign field_next = (field_q == ST_WEEK || field_q == ST_FORMAT) ?
                      ST_SEC : rtc_field_t'(field_q + 4'd1);
  assign field_prev = (field_q == ST_SEC || field_q == ST_FORMAT) ?
                      ST_WEEK : rtc_field_t'(field_q - 4'd1);

  always_comb
  begin
    field_d = field_q;
    cmd_d   = CMD_NONE;
    busy_d  = busy_q;
    if (field_q == ST_INIT)
    begin
      if (init_rise && !init_lvl_i)
      begin
        cmd_d   = CMD_RUN; // settle time over, release the chip
        busy_d  = 1'b0;
        field_d = ST_FORMAT;
      end
      else if (init_press_i)
      begin
        cmd_d = CMD_HALT;
      end
    end
    else if (hold_rise)
    begin
      cmd_d   = CMD_CLEAR; // long press done
      busy_d  = 1'b0;
      field_d = ST_FORMAT;
    end
    else
    begin
      if (reset_press_i)
      begin
        busy_d = 1'b1;
      end
      if (edit_en_i)
      begin
        if (up_i)
        begin
          cmd_d = (field_q == ST_FORMAT) ? CMD_FORMAT : CMD_INC;
        end
        else if (down_i && field_q != ST_FORMAT)
        begin
          cmd_d = CMD_DEC;
        end
        else if (right_i)
        begin
          field_d = field_next;
        end
        else if (left_i)
        begin
          field_d = field_prev;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      field_q     <= ST_INIT;
      cmd_q       <= CMD_NONE;
      busy_q      <= 1'b1; // busy until the chip is released
      init_done_q <= 1'b0;
      hold_done_q <= 1'b0;
    end
    else
    begin
      field_q     <= field_d;
      cmd_q       <= cmd_d;
      busy_q      <= busy_d;
      init_done_q <= init_done_i;
      hold_done_q <= hold_done_i;
    end
  end

  assign field_o = field_q;
  assign cmd_o   = cmd_q;
  assign busy_o  = busy_q;

  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    field_q inside {[ST_INIT:ST_WEEK]}
  );

  a_adjust_in_field: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    cmd_q inside {CMD_INC, CMD_DEC} |-> !(field_q inside {ST_INIT, ST_FORMAT})
  );

endmodule

// ==== field_write.sv ====
module field_write
  import rtc_set_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  wr_cmd_t          cmd_i,
  input  rtc_field_t       field_i,
  input  logic [RTC_W-1:0] sec_i,
  input  logic [RTC_W-1:0] min_i,
  input  logic [RTC_W-1:0] hour_i,
  input  logic [RTC_W-1:0] date_i,
  input  logic [RTC_W-1:0] month_i,
  input  logic [RTC_W-1:0] year_i,
  input  logic [RTC_W-1:0] wday_i,
  input  logic [RTC_W-1:0] week_i,
  output logic [RTC_W-1:0] rtc_addr_o,
  output logic [RTC_W-1:0] rtc_data_o,
  output logic             rtc_wr_o
);

  logic [RTC_W-1:0] fld_addr;
  logic [RTC_W-1:0] fld_val;
  logic [RTC_W-1:0] wr_addr;
  logic [RTC_W-1:0] wr_data;
  logic [RTC_W-1:0] addr_q;
  logic [RTC_W-1:0] data_q;
  logic             wr_q;

  always_comb
  begin
    fld_addr = ADDR_FORMAT;
    fld_val  = '0;
    case (field_i)
      ST_SEC:   {fld_addr, fld_val} = {ADDR_SEC, sec_i};
      ST_MIN:   {fld_addr, fld_val} = {ADDR_MIN, min_i};
      ST_HOUR:  {fld_addr, fld_val} = {ADDR_HOUR, hour_i};
      ST_DATE:  {fld_addr, fld_val} = {ADDR_DATE, date_i};
      ST_MONTH: {fld_addr, fld_val} = {ADDR_MONTH, month_i};
      ST_YEAR:  {fld_addr, fld_val} = {ADDR_YEAR, year_i};
      ST_WDAY:  {fld_addr, fld_val} = {ADDR_WDAY, wday_i};
      ST_WEEK:  {fld_addr, fld_val} = {ADDR_WEEK, week_i};
      default:  {fld_addr, fld_val} = {ADDR_FORMAT, {RTC_W{1'b0}}};
    endcase
  end

  always_comb
  begin
    wr_addr = fld_addr;
    wr_data = fld_val;
    case (cmd_i)
      CMD_HALT:   {wr_addr, wr_data} = {ADDR_CTRL, DATA_HALT};
      CMD_RUN:    {wr_addr, wr_data} = {ADDR_CTRL, DATA_RUN};
      CMD_FORMAT: {wr_addr, wr_data} = {ADDR_FORMAT, DATA_FORMAT};
      CMD_CLEAR:  {wr_addr, wr_data} = {ADDR_FORMAT, DATA_CLEAR};
      CMD_INC:    wr_data = fld_val + 1'b1; // wraps mod 256
      CMD_DEC:    wr_data = fld_val - 1'b1;
      default:    wr_data = fld_val;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      addr_q <= '0;
      data_q <= '0;
      wr_q   <= 1'b0;
    end
    else
    begin
      wr_q <= (cmd_i != CMD_NONE);
      if (cmd_i != CMD_NONE)
      begin
        addr_q <= wr_addr; // held until the next write
        data_q <= wr_data;
      end
    end
  end

  assign rtc_addr_o = addr_q;
  assign rtc_data_o = data_q;
  assign rtc_wr_o   = wr_q;

  // relies on the FSM issuing single-cycle commands
  a_wr_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    rtc_wr_o |=> !rtc_wr_o
  );

endmodule

// ==== rtc_set_top.sv ====
module rtc_set_top
  import rtc_set_pkg::*;
#(
  parameter int INIT_CYCLES = 768,
  parameter int HOLD_CYCLES = 2048,
  parameter int CNT_W       = 12
)
(
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             init_key_i,
  input  logic             reset_key_i,
  input  logic             edit_en_i,
  input  logic             up_key_i,
  input  logic             down_key_i,
  input  logic             left_key_i,
  input  logic             right_key_i,
  input  logic [RTC_W-1:0] sec_i,
  input  logic [RTC_W-1:0] min_i,
  input  logic [RTC_W-1:0] hour_i,
  input  logic [RTC_W-1:0] date_i,
  input  logic [RTC_W-1:0] month_i,
  input  logic [RTC_W-1:0] year_i,
  input  logic [RTC_W-1:0] wday_i,
  input  logic [RTC_W-1:0] week_i,
  output logic [RTC_W-1:0] rtc_addr_o,
  output logic [RTC_W-1:0] rtc_data_o,
  output logic             rtc_wr_o,
  output logic             busy_o
);

  logic       init_lvl;
  logic       init_press;
  logic       reset_lvl;
  logic       reset_press;
  logic       up_press;
  logic       down_press;
  logic       left_press;
  logic       right_press;
  logic       init_done;
  logic       hold_done;
  rtc_field_t field;
  wr_cmd_t    cmd;

  key_pulse u_key_init  (.clk, .rst_n_i, .key_i(init_key_i),  .level_o(init_lvl),
                         .press_o(init_press));
  key_pulse u_key_reset (.clk, .rst_n_i, .key_i(reset_key_i), .level_o(reset_lvl),
                         .press_o(reset_press));
  key_pulse u_key_up    (.clk, .rst_n_i, .key_i(up_key_i),    .level_o(),
                         .press_o(up_press));
  key_pulse u_key_down  (.clk, .rst_n_i, .key_i(down_key_i),  .level_o(),
                         .press_o(down_press));
  key_pulse u_key_left  (.clk, .rst_n_i, .key_i(left_key_i),  .level_o(),
                         .press_o(left_press));
  key_pulse u_key_right (.clk, .rst_n_i, .key_i(right_key_i), .level_o(),
                         .press_o(right_press));

  // settle time runs with both control keys released
  hold_timer #(.LIMIT(INIT_CYCLES), .CNT_W(CNT_W)) u_init_timer (
    .clk, .rst_n_i, .run_i(!init_lvl && !reset_lvl), .done_o(init_done)
  );

  hold_timer #(.LIMIT(HOLD_CYCLES), .CNT_W(CNT_W)) u_hold_timer (
    .clk, .rst_n_i, .run_i(reset_lvl), .done_o(hold_done)
  );

  rtc_set_fsm u_fsm (
    .clk, .rst_n_i, .edit_en_i,
    .init_lvl_i(init_lvl), .init_press_i(init_press), .reset_press_i(reset_press),
    .up_i(up_press), .down_i(down_press), .left_i(left_press), .right_i(right_press),
    .init_done_i(init_done), .hold_done_i(hold_done),
    .field_o(field), .cmd_o(cmd), .busy_o
  );

  field_write u_field_write (
    .clk, .rst_n_i, .cmd_i(cmd), .field_i(field),
    .sec_i, .min_i, .hour_i, .date_i, .month_i, .year_i, .wday_i, .week_i,
    .rtc_addr_o, .rtc_data_o, .rtc_wr_o
  );

endmodule

// ==== tb_rtc_set.sv ====
module tb_rtc_set
  import rtc_set_pkg::*;
();

  localparam int K_UP    = 0;
  localparam int K_DOWN  = 1;
  localparam int K_LEFT  = 2;
  localparam int K_RIGHT = 3;
  localparam int K_INIT  = 4;

  logic        clk;
  logic        rst_n_i;
  logic        init_key_i;
  logic        reset_key_i;
  logic        edit_en_i;
  logic        up_key_i;
  logic        down_key_i;
  logic        left_key_i;
  logic        right_key_i;
  logic [63:0] live; // sec in the low byte, week in the top byte
  logic [7:0]  rtc_addr_o;
  logic [7:0]  rtc_data_o;
  logic        rtc_wr_o;
  logic        busy_o;
  logic [15:0] exp_q[$]; // expected {addr, data} in write order
  logic [15:0] exp_wr;
  rtc_field_t  order[8];
  int          errors = 0;
  int          checks = 0;
  int          wr_count = 0;
  int          seed_dummy;
  int          lat;
  int          mark;
  int          mark_wr;

  rtc_set_top #(.INIT_CYCLES(32), .HOLD_CYCLES(64)) u_rtc_set_top (
    .clk, .rst_n_i, .init_key_i, .reset_key_i, .edit_en_i,
    .up_key_i, .down_key_i, .left_key_i, .right_key_i,
    .sec_i(live[7:0]), .min_i(live[15:8]), .hour_i(live[23:16]), .date_i(live[31:24]),
    .month_i(live[39:32]), .year_i(live[47:40]), .wday_i(live[55:48]),
    .week_i(live[63:56]),
    .rtc_addr_o, .rtc_data_o, .rtc_wr_o, .busy_o
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // expected write for a command in a given field
  function automatic logic [15:0] ref_write(input wr_cmd_t cmd, input rtc_field_t fld,
                                            input logic [63:0] vals);
    logic [7:0] addr;
    logic [7:0] val;
    int         idx;
    addr = 8'h00;
    val  = 8'h00;
    idx  = -1;
    case (fld)
      ST_SEC:   idx = 0;
      ST_MIN:   idx = 1;
      ST_HOUR:  idx = 2;
      ST_DATE:  idx = 3;
      ST_MONTH: idx = 4;
      ST_YEAR:  idx = 5;
      ST_WDAY:  idx = 6;
      ST_WEEK:  idx = 7;
      default:  idx = -1;
    endcase
    if (idx >= 0)
    begin
      addr = 8'h21 + idx[7:0]; // field registers sit at 0x21 upward
      val  = vals[8*idx +: 8];
    end
    case (cmd)
      CMD_HALT:   return {8'h02, 8'h10};
      CMD_RUN:    return {8'h02, 8'h00};
      CMD_FORMAT: return {8'h00, 8'h10};
      CMD_CLEAR:  return {8'h00, 8'h00};
      CMD_INC:    return {addr, val + 8'd1};
      CMD_DEC:    return {addr, val - 8'd1};
      default:    return {addr, val};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR at %0t: %s = 'h%0h, expected 'h%0h", $time, name, got, exp);
    end
  endtask

  task automatic push_write(input logic [15:0] wr);
    exp_q.push_back(wr);
  endtask

  task automatic wait_queue(input int left, input string what);
    int n;
    n = 0;
    while (exp_q.size() > left && n < 300)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() > left)
    begin
      errors++;
      $display("timeout at %0t waiting for the %s", $time, what);
      exp_q.delete();
    end
  endtask

  task automatic set_key(input int k, input logic v);
    case (k)
      K_UP:    up_key_i = v;
      K_DOWN:  down_key_i = v;
      K_LEFT:  left_key_i = v;
      K_RIGHT: right_key_i = v;
      default: init_key_i = v;
    endcase
  endtask

  task automatic press_key(input int k);
    @(negedge clk);
    set_key(k, 1'b1);
    repeat (3) @(negedge clk);
    set_key(k, 1'b0);
    repeat (3) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int err_mark);
    $display("test %s finished with %0d errors", name, errors - err_mark);
  endtask

  // every write strobe is matched against the head of the expected queue
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n_i && rtc_wr_o)
      begin
        wr_count++;
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("unexpected write to address 'h%0h at %0t", rtc_addr_o, $time);
        end
        else
        begin
          exp_wr = exp_q.pop_front();
          check_value("rtc_addr_o", rtc_addr_o, exp_wr[15:8]);
          check_value("rtc_data_o", rtc_data_o, exp_wr[7:0]);
        end
      end
    end
  end

  initial
  begin
    seed_dummy  = $urandom(32'h4282);
    live        = {$urandom, $urandom};
    order       = '{ST_SEC, ST_MIN, ST_HOUR, ST_DATE, ST_MONTH, ST_YEAR, ST_WDAY, ST_WEEK};
    rst_n_i     = 1'b0;
    init_key_i  = 1'b0;
    reset_key_i = 1'b0;
    edit_en_i   = 1'b1;
    up_key_i    = 1'b0;
    down_key_i  = 1'b0;
    left_key_i  = 1'b0;
    right_key_i = 1'b0;
    repeat (5) @(negedge clk);
    rst_n_i = 1'b1;

    mark = errors; // press init before the settle time runs out
    push_write(ref_write(CMD_HALT, ST_INIT, live));
    push_write(ref_write(CMD_RUN, ST_INIT, live));
    press_key(K_INIT);
    wait_queue(1, "halt write");
    check_value("busy_o", busy_o, 1);
    wait_queue(0, "run write");
    check_value("busy_o", busy_o, 0);
    end_test("startup", mark);

    mark = errors;
    push_write(ref_write(CMD_FORMAT, ST_FORMAT, live));
    @(negedge clk);
    up_key_i = 1'b1;
    @(negedge clk); // first sampling edge has passed
    lat = 0;
    while (!rtc_wr_o && lat < 20)
    begin
      @(negedge clk);
      lat++;
    end
    check_value("write latency", lat, 4);
    up_key_i = 1'b0;
    wait_queue(0, "format write");
    end_test("format", mark);

    mark = errors;
    press_key(K_RIGHT);
    push_write(ref_write(CMD_INC, ST_SEC, live));
    press_key(K_UP);
    push_write(ref_write(CMD_DEC, ST_SEC, live));
    press_key(K_DOWN);
    wait_queue(0, "adjust writes");
    end_test("adjust", mark);

    mark = errors;
    for (int i = 0; i < 8; i++)
    begin
      if (i > 0)
      begin
        press_key(K_RIGHT);
      end
      push_write(ref_write(CMD_INC, order[i], live));
      press_key(K_UP);
    end
    press_key(K_RIGHT); // week wraps to seconds
    push_write(ref_write(CMD_INC, ST_SEC, live));
    press_key(K_UP);
    press_key(K_LEFT);
    push_write(ref_write(CMD_INC, ST_WEEK, live));
    press_key(K_UP);
    wait_queue(0, "navigation writes");
    end_test("navigation", mark);

    mark = errors;
    push_write(ref_write(CMD_CLEAR, ST_WEEK, live));
    @(negedge clk);
    reset_key_i = 1'b1;
    lat = 0;
    while (!busy_o && lat < 20)
    begin
      @(negedge clk);
      lat++;
    end
    check_value("busy_o", busy_o, 1);
    wait_queue(0, "clear write");
    @(negedge clk);
    reset_key_i = 1'b0;
    check_value("busy_o", busy_o, 0);
    push_write(ref_write(CMD_FORMAT, ST_FORMAT, live));
    press_key(K_UP);
    wait_queue(0, "format write after reset");
    end_test("long-press reset", mark);

    mark = errors;
    @(negedge clk);
    edit_en_i = 1'b0;
    mark_wr = wr_count;
    press_key(K_UP);
    press_key(K_DOWN);
    press_key(K_RIGHT);
    press_key(K_LEFT);
    repeat (40) @(negedge clk);
    check_value("write count", wr_count, mark_wr);
    edit_en_i = 1'b1;
    end_test("edit enable", mark);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtc_set_pkg.sv
key_pulse.sv
hold_timer.sv
rtc_set_fsm.sv
field_write.sv
rtc_set_top.sv
tb_rtc_set.sv
